// File: Makefile
# Verilator build and run for the ZX-Uno I/O register bank

VERILATOR ?= verilator
TOP       ?= tb_zxuno_io
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Test FAILED
PASS_MSG  ?= Test OK

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; \
		exit 1; \
	fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/config_registers.sv
`timescale 1ns/1ps

module config_registers #(
  parameter logic [2:0] BOARD_MODEL = 3'd0
) (
  input  logic                   sysclk,
  input  logic                   reset,
  input  zxio_pkg::reg_access_t  regacc,
  input  logic [7:0]             wdata,
  output logic [7:0]             dout,
  output logic                   oe,
  output zxio_pkg::dev_options_t dev_options
);

  logic [7:0]             scratch;
  zxio_pkg::dev_options_t devopt;

  // --------------------------------------------------
  // Register writes
  // --------------------------------------------------
  always_ff @(posedge sysclk) begin
    if (reset) begin
      scratch <= 8'h00;
      devopt  <= '0;
    end else if (regacc.wr) begin
      case (regacc.addr)
        zxio_pkg::REG_SCRATCH: begin
          scratch <= wdata;
        end
        zxio_pkg::REG_DEVOPTIONS: begin
          devopt <= zxio_pkg::dev_options_t'(wdata);
        end
        // Board capabilities is read only
        default: begin
        end
      endcase
    end
  end

  // --------------------------------------------------
  // Read back
  // --------------------------------------------------
  always_comb begin
    dout = 8'h00;
    oe   = 1'b0;
    case (regacc.addr)
      zxio_pkg::REG_SCRATCH: begin
        dout = scratch;
        oe   = regacc.rd;
      end
      zxio_pkg::REG_DEVOPTIONS: begin
        dout = devopt;
        oe   = regacc.rd;
      end
      zxio_pkg::REG_BOARDCAP: begin
        dout = {5'b00000, BOARD_MODEL};
        oe   = regacc.rd;
      end
      default: begin
      end
    endcase
  end

  assign dev_options = devopt;

  a_oe_only_on_read: assert property (
    @(posedge sysclk) disable iff (reset) oe |-> regacc.rd
  ) else $error("config_registers: oe high outside a data port read");

endmodule

// File: design/coreid_reg.sv
`timescale 1ns/1ps

module coreid_reg (
  input  logic                  sysclk,
  input  logic                  reset,
  input  zxio_pkg::reg_access_t regacc,
  output logic [7:0]            dout,
  output logic                  oe
);

  // Index runs 0 to COREID_LEN, the last value is the terminator
  localparam int IDX_W = $clog2(zxio_pkg::COREID_LEN + 1);
  localparam int SEL_W = $clog2(zxio_pkg::COREID_LEN);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(zxio_pkg::COREID_LEN);

  logic [IDX_W-1:0] idx;
  logic [SEL_W-1:0] byte_sel;
  logic             coreid_rd;
  logic             coreid_rd_prev;
  logic             rd_done;

  assign coreid_rd = regacc.rd && (regacc.addr == zxio_pkg::REG_COREID);

  // Read has just ended
  assign rd_done = coreid_rd_prev & ~coreid_rd;

  always_ff @(posedge sysclk) begin
    if (reset) begin
      idx            <= '0;
      coreid_rd_prev <= 1'b0;
    end else begin
      coreid_rd_prev <= coreid_rd;
      if (regacc.addr_changed) begin
        idx <= '0;
      end else if (rd_done) begin
        idx <= (idx == LAST_IDX) ? '0 : idx + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // Byte lookup
  // --------------------------------------------------
  // First character sits in the top byte of the text
  assign byte_sel = SEL_W'(LAST_IDX - 1'b1 - idx);

  always_comb begin
    if (idx == LAST_IDX) begin
      dout = 8'h00;
    end else begin
      dout = zxio_pkg::COREID_TEXT[byte_sel];
    end
  end

  assign oe = coreid_rd;

  a_idx_in_range: assert property (
    @(posedge sysclk) disable iff (reset) idx <= LAST_IDX
  ) else $error("coreid_reg: index %0d past end of string", idx);

endmodule

// File: design/cpu_data_select.sv
`timescale 1ns/1ps

module cpu_data_select (
  input  zxio_pkg::cpu_bus_t bus,
  input  logic               addr_oe,
  input  logic [7:0]         addr_dout,
  input  logic               coreid_oe,
  input  logic [7:0]         coreid_dout,
  input  logic               cfg_oe,
  input  logic [7:0]         cfg_dout,
  output logic [7:0]         cpu_din
);

  logic int_ack;

  // Interrupt acknowledge puts 0xFF on the bus
  assign int_ack = ~bus.iorq_n & ~bus.m1_n;

  // --------------------------------------------------
  // Priority selector, acknowledge first
  // --------------------------------------------------
  always_comb begin
    case (1'b1)
      int_ack:   cpu_din = zxio_pkg::BUS_IDLE_BYTE;
      addr_oe:   cpu_din = addr_dout;
      coreid_oe: cpu_din = coreid_dout;
      cfg_oe:    cpu_din = cfg_dout;
      default:   cpu_din = zxio_pkg::BUS_IDLE_BYTE;
    endcase
  end

  // Enables come from separate devices, checked once values settle
  always_comb begin
    a_one_source: assert final ($onehot0({addr_oe, coreid_oe, cfg_oe}))
      else $error("cpu_data_select: more than one device drives the bus");
  end

endmodule

// File: design/zxio_pkg.sv
package zxio_pkg;

  // --------------------------------------------------
  // I/O ports and fixed bus values
  // --------------------------------------------------
  localparam logic [15:0] ZXUNO_ADDR_PORT = 16'hFC3B;
  localparam logic [15:0] ZXUNO_DATA_PORT = 16'hFD3B;

  // Floating bus, also forced during interrupt acknowledge
  localparam logic [7:0] BUS_IDLE_BYTE = 8'hFF;

  // Core ID string, first character in the top byte
  localparam int COREID_LEN = 8;
  localparam logic [COREID_LEN-1:0][7:0] COREID_TEXT = "ZXIO-1.0";

  // --------------------------------------------------
  // Register bank addresses
  // --------------------------------------------------
  typedef enum logic [7:0] {
    REG_DEVOPTIONS = 8'h0E,
    REG_BOARDCAP   = 8'hFD,
    REG_SCRATCH    = 8'hFE,
    REG_COREID     = 8'hFF
  } reg_addr_e;

  // --------------------------------------------------
  // Bus and register structures
  // --------------------------------------------------
  // Z80 view of one bus cycle
  typedef struct packed {
    logic [15:0] addr;
    logic [7:0]  dout;
    logic        iorq_n;
    logic        rd_n;
    logic        wr_n;
    logic        m1_n;
  } cpu_bus_t;

  // Current register plus data port strobes
  typedef struct packed {
    logic [7:0] addr;
    logic       rd;
    logic       wr;
    logic       addr_changed;
  } reg_access_t;

  // Device options, bit 7 down to bit 0
  typedef struct packed {
    logic disable_spisd;
    logic enable_timexmmu;
    logic disable_romsel1f;
    logic disable_romsel7f;
    logic disable_1ffd;
    logic disable_7ffd;
    logic disable_turboay;
    logic disable_ay;
  } dev_options_t;

endpackage

// File: design/zxuno_addr_reg.sv
`timescale 1ns/1ps

module zxuno_addr_reg (
  input  logic                  sysclk,
  input  logic                  reset,
  input  zxio_pkg::cpu_bus_t    bus,
  output zxio_pkg::reg_access_t regacc,
  output logic                  addr_oe,
  output logic [7:0]            addr_dout
);

  logic       io_cycle;
  logic       addr_port_hit;
  logic       data_port_hit;
  logic       addr_wr_now;
  logic       data_wr_now;
  logic       addr_wr_prev;
  logic       data_wr_prev;
  logic       addr_wr_start;
  logic [7:0] reg_addr;

  // --------------------------------------------------
  // Port decode
  // --------------------------------------------------
  // Interrupt acknowledge is not an I/O access
  assign io_cycle      = ~bus.iorq_n & bus.m1_n;
  assign addr_port_hit = io_cycle && (bus.addr == zxio_pkg::ZXUNO_ADDR_PORT);
  assign data_port_hit = io_cycle && (bus.addr == zxio_pkg::ZXUNO_DATA_PORT);

  assign addr_wr_now = addr_port_hit & ~bus.wr_n;
  assign data_wr_now = data_port_hit & ~bus.wr_n;

  // First cycle of a write only
  assign addr_wr_start = addr_wr_now & ~addr_wr_prev;

  // --------------------------------------------------
  // Previous access state and register address
  // --------------------------------------------------
  always_ff @(posedge sysclk) begin
    if (reset) begin
      addr_wr_prev <= 1'b0;
      data_wr_prev <= 1'b0;
      reg_addr     <= 8'h00;
    end else begin
      addr_wr_prev <= addr_wr_now;
      data_wr_prev <= data_wr_now;
      if (addr_wr_start) begin
        reg_addr <= bus.dout;
      end
    end
  end

  // Strobes to the register devices
  assign regacc.addr         = reg_addr;
  assign regacc.rd           = data_port_hit & ~bus.rd_n;
  assign regacc.wr           = data_wr_now & ~data_wr_prev;
  assign regacc.addr_changed = addr_wr_start;

  // Address port reads back the selected register
  assign addr_oe   = addr_port_hit & ~bus.rd_n;
  assign addr_dout = reg_addr;

  a_rd_wr_exclusive: assert property (
    @(posedge sysclk) disable iff (reset) !(regacc.rd && regacc.wr)
  ) else $error("zxuno_addr_reg: data port rd and wr strobes high together");

endmodule

// File: design/zxuno_io.sv
`timescale 1ns/1ps

module zxuno_io #(
  parameter logic [2:0] BOARD_MODEL = 3'd0
) (
  input  logic                   sysclk,
  input  logic                   reset,
  input  zxio_pkg::cpu_bus_t     bus,
  output logic [7:0]             cpu_din,
  output zxio_pkg::dev_options_t dev_options
);

  // Register bank access from the port decoder
  zxio_pkg::reg_access_t regacc;

  // Address port read back
  logic       addr_oe;
  logic [7:0] addr_dout;

  // Core ID
  logic       coreid_oe;
  logic [7:0] coreid_dout;

  // Scratch, options and capabilities
  logic       cfg_oe;
  logic [7:0] cfg_dout;

  // --------------------------------------------------
  // Port decoder and register address
  // --------------------------------------------------
  zxuno_addr_reg port_decoder (
    .sysclk      (sysclk     ),
    .reset       (reset      ),
    .bus         (bus        ),
    .regacc      (regacc     ),
    .addr_oe     (addr_oe    ),
    .addr_dout   (addr_dout  ));

  // --------------------------------------------------
  // Register devices
  // --------------------------------------------------
  coreid_reg core_identification (
    .sysclk      (sysclk     ),
    .reset       (reset      ),
    .regacc      (regacc     ),
    .dout        (coreid_dout),
    .oe          (coreid_oe  ));

  config_registers #(
    .BOARD_MODEL (BOARD_MODEL)
  ) config_bank (
    .sysclk      (sysclk     ),
    .reset       (reset      ),
    .regacc      (regacc     ),
    .wdata       (bus.dout   ),
    .dout        (cfg_dout   ),
    .oe          (cfg_oe     ),
    .dev_options (dev_options));

  // CPU input data
  cpu_data_select read_mux (
    .bus         (bus        ),
    .addr_oe     (addr_oe    ),
    .addr_dout   (addr_dout  ),
    .coreid_oe   (coreid_oe  ),
    .coreid_dout (coreid_dout),
    .cfg_oe      (cfg_oe     ),
    .cfg_dout    (cfg_dout   ),
    .cpu_din     (cpu_din    ));

endmodule

// File: filelist.f
+incdir+tb
design/zxio_pkg.sv
design/zxuno_addr_reg.sv
design/coreid_reg.sv
design/config_registers.sv
design/cpu_data_select.sv
design/zxuno_io.sv
tb/tb_zxuno_io.sv

// File: tb/tb_bus_tasks.svh
`ifndef TB_BUS_TASKS_SVH
`define TB_BUS_TASKS_SVH

// --------------------------------------------------
// Z80 bus cycles
// --------------------------------------------------
// Each access is held for 3 cycles, then 1 idle cycle
task automatic io_write(input logic [15:0] port, input logic [7:0] data);
  zxio_pkg::cpu_bus_t acc;
  acc        = BUS_IDLE;
  acc.addr   = port;
  acc.dout   = data;
  acc.iorq_n = 1'b0;
  acc.wr_n   = 1'b0;
  @(posedge sysclk);
  bus <= acc;
  repeat (3) @(posedge sysclk);
  bus <= BUS_IDLE;
endtask

task automatic io_read(input logic [15:0] port, output logic [7:0] data);
  zxio_pkg::cpu_bus_t acc;
  acc        = BUS_IDLE;
  acc.addr   = port;
  acc.iorq_n = 1'b0;
  acc.rd_n   = 1'b0;
  @(posedge sysclk);
  bus <= acc;
  @(posedge sysclk);
  // Mid cycle, well away from the edges
  @(negedge sysclk);
  data = cpu_din;
  repeat (2) @(posedge sysclk);
  bus <= BUS_IDLE;
endtask

task automatic int_ack(output logic [7:0] data);
  zxio_pkg::cpu_bus_t acc;
  acc        = BUS_IDLE;
  acc.addr   = 16'h00FF;
  acc.iorq_n = 1'b0;
  acc.m1_n   = 1'b0;
  @(posedge sysclk);
  bus <= acc;
  @(posedge sysclk);
  @(negedge sysclk);
  data = cpu_din;
  repeat (2) @(posedge sysclk);
  bus <= BUS_IDLE;
endtask

// --------------------------------------------------
// Compare helpers
// --------------------------------------------------
task automatic check_byte(input string name, input logic [7:0] expected,
                          input logic [7:0] actual);
  if (actual !== expected) begin
    error_count++;
    $display("ERROR at %0t ns: %s expected 0x%02h, got 0x%02h",
             $time, name, expected, actual);
  end
endtask

task automatic check_options(input string name, input zxio_pkg::dev_options_t expected,
                             input zxio_pkg::dev_options_t actual);
  if (actual !== expected) begin
    error_count++;
    $display("ERROR at %0t ns: %s expected 0x%02h, got 0x%02h",
             $time, name, expected, actual);
  end
endtask

`endif

// File: tb/tb_zxuno_io.sv
`timescale 1ns/1ps

module tb_zxuno_io;

  localparam int CLK_PERIOD = 40;
  localparam int NUM_TESTS  = 6;
  localparam logic [2:0] BOARD_MODEL = 3'd5;

  // All strobes inactive, nothing on the bus
  localparam zxio_pkg::cpu_bus_t BUS_IDLE = '{
    addr: 16'h0000, dout: 8'h00, iorq_n: 1'b1, rd_n: 1'b1, wr_n: 1'b1, m1_n: 1'b1
  };

  logic                   sysclk = 1'b0;
  logic                   reset;
  zxio_pkg::cpu_bus_t     bus;
  logic [7:0]             cpu_din;
  zxio_pkg::dev_options_t dev_options;

  integer seed        = 41068;
  int     error_count = 0;
  int     pass_count  = 0;
  int     fail_count  = 0;

  zxuno_io #(
    .BOARD_MODEL (BOARD_MODEL)
  ) uut (
    .sysclk      (sysclk     ),
    .reset       (reset      ),
    .bus         (bus        ),
    .cpu_din     (cpu_din    ),
    .dev_options (dev_options));

  always #(CLK_PERIOD / 2) sysclk = ~sysclk;

  `include "tb_bus_tasks.svh"

  task automatic select_register(input logic [7:0] reg_addr);
    io_write(zxio_pkg::ZXUNO_ADDR_PORT, reg_addr);
  endtask

  task automatic report_test(input string name, input int start_errors);
    if (error_count == start_errors) begin
      pass_count++;
      $display("%s: no mismatches", name);
    end else begin
      fail_count++;
      $display("%s: %0d mismatches", name, error_count - start_errors);
    end
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic test_addr_register();
    int         start_errors;
    logic [7:0] wdata;
    logic [7:0] rdata;
    start_errors = error_count;
    // Reset value first
    io_read(zxio_pkg::ZXUNO_ADDR_PORT, rdata);
    check_byte("cpu_din", 8'h00, rdata);
    repeat (4) begin
      wdata = 8'($random(seed));
      io_write(zxio_pkg::ZXUNO_ADDR_PORT, wdata);
      io_read(zxio_pkg::ZXUNO_ADDR_PORT, rdata);
      check_byte("cpu_din", wdata, rdata);
    end
    report_test("address register", start_errors);
  endtask

  task automatic test_scratch();
    int         start_errors;
    logic [7:0] wdata;
    logic [7:0] rdata;
    start_errors = error_count;
    select_register(zxio_pkg::REG_SCRATCH);
    repeat (6) begin
      wdata = 8'($random(seed));
      io_write(zxio_pkg::ZXUNO_DATA_PORT, wdata);
      io_read(zxio_pkg::ZXUNO_DATA_PORT, rdata);
      check_byte("cpu_din", wdata, rdata);
    end
    report_test("scratch register", start_errors);
  endtask

  task automatic test_dev_options();
    int         start_errors;
    logic [7:0] wdata;
    logic [7:0] rdata;
    start_errors = error_count;
    select_register(zxio_pkg::REG_DEVOPTIONS);
    repeat (6) begin
      wdata = 8'($random(seed));
      io_write(zxio_pkg::ZXUNO_DATA_PORT, wdata);
      io_read(zxio_pkg::ZXUNO_DATA_PORT, rdata);
      check_byte("cpu_din", wdata, rdata);
      check_options("dev_options", zxio_pkg::dev_options_t'(wdata), dev_options);
    end
    report_test("device options", start_errors);
  endtask

  task automatic test_coreid();
    int         start_errors;
    string      expected_id;
    logic [7:0] rdata;
    start_errors = error_count;
    expected_id  = "ZXIO-1.0";
    select_register(zxio_pkg::REG_COREID);
    for (int i = 0; i < expected_id.len(); i++) begin
      io_read(zxio_pkg::ZXUNO_DATA_PORT, rdata);
      check_byte("cpu_din", expected_id[i], rdata);
    end
    // Terminator, then the string wraps
    io_read(zxio_pkg::ZXUNO_DATA_PORT, rdata);
    check_byte("cpu_din", 8'h00, rdata);
    io_read(zxio_pkg::ZXUNO_DATA_PORT, rdata);
    check_byte("cpu_din", expected_id[0], rdata);
    io_read(zxio_pkg::ZXUNO_DATA_PORT, rdata);
    check_byte("cpu_din", expected_id[1], rdata);
    // Reselect mid string
    select_register(zxio_pkg::REG_COREID);
    io_read(zxio_pkg::ZXUNO_DATA_PORT, rdata);
    check_byte("cpu_din", expected_id[0], rdata);
    report_test("core id", start_errors);
  endtask

  task automatic test_board_cap();
    int         start_errors;
    logic [7:0] rdata;
    start_errors = error_count;
    select_register(zxio_pkg::REG_BOARDCAP);
    io_read(zxio_pkg::ZXUNO_DATA_PORT, rdata);
    check_byte("cpu_din", 8'h05, rdata);
    io_write(zxio_pkg::ZXUNO_DATA_PORT, 8'($random(seed)));
    io_read(zxio_pkg::ZXUNO_DATA_PORT, rdata);
    check_byte("cpu_din", 8'h05, rdata);
    report_test("board capabilities", start_errors);
  endtask

  task automatic test_idle_bytes();
    int         start_errors;
    logic [7:0] rdata;
    start_errors = error_count;
    // Unmapped registers
    select_register(8'h42);
    io_read(zxio_pkg::ZXUNO_DATA_PORT, rdata);
    check_byte("cpu_din", 8'hFF, rdata);
    select_register(8'h00);
    io_read(zxio_pkg::ZXUNO_DATA_PORT, rdata);
    check_byte("cpu_din", 8'hFF, rdata);
    // Ports outside the bank
    io_read(16'h00FE, rdata);
    check_byte("cpu_din", 8'hFF, rdata);
    io_read(16'h7FFD, rdata);
    check_byte("cpu_din", 8'hFF, rdata);
    int_ack(rdata);
    check_byte("cpu_din", 8'hFF, rdata);
    report_test("idle and acknowledge", start_errors);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    reset = 1'b1;
    bus   = BUS_IDLE;
    repeat (4) @(posedge sysclk);
    reset <= 1'b0;

    test_addr_register();
    test_scratch();
    test_dev_options();
    test_coreid();
    test_board_cap();
    test_idle_bytes();

    $display("Summary: %0d tests passed, %0d tests failed", pass_count, fail_count);
    if (fail_count == 0 && error_count == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Watchdog, 200 cycles per test
  initial begin
    #(NUM_TESTS * 200 * CLK_PERIOD);
    $display("Watchdog expired before the tests completed");
    $display("Test FAILED");
    $finish;
  end

endmodule
